/* Makefile */
# Verilator build and run for the increment node testbench

VERILATOR ?= verilator
TOP       ?= tb_increment_top
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_increment_top.sv */
// Testbench for the increment node top level
// Drives serial frames and the button, decodes the outgoing frames on
// tx_line and checks the bytes and the digit patterns.

`timescale 1ns/1ps
`default_nettype none

module tb_increment_top
	import node_pkg::*, link_pkg::*;
();

	localparam int START_TIMEOUT = 4000; // cycles allowed for a frame to start

	logic       clk;
	logic       reset;
	logic       button;
	logic       mode_switch;
	logic [7:0] sw_data;
	logic       rx_line;
	wire        tx_line;
	seg_t       display_low;
	seg_t       display_high;
	logic [31:0] lcg_state;

	increment_top i_dut
	(
		.clk          (clk),
		.reset        (reset),
		.button       (button),
		.mode_switch  (mode_switch),
		.sw_data      (sw_data),
		.rx_line      (rx_line),
		.tx_line      (tx_line),
		.display_low  (display_low),
		.display_high (display_high)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16]; // upper bits are the better ones
	endfunction

	// standard hex digits, segment a in bit 0
	function automatic seg_t seg_ref(input logic [3:0] nibble);
		seg_t table_pat [16];
		table_pat = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
			7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
		return table_pat[nibble];
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic send_frame(input logic [7:0] data);
		logic [9:0] frame;
		frame = {LINE_IDLE, data, ~LINE_IDLE}; // start bit goes out first
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			rx_line <= frame[i];
			repeat (BIT_CYCLES - 1) @(posedge clk);
		end
	endtask

	// waits for a start bit, then samples every bit in its middle
	task automatic receive_frame(output logic [7:0] data, output seg_t low, output seg_t high);
		int waited;
		waited = 0;
		@(negedge clk);
		while (tx_line !== 1'b0 && waited < START_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (tx_line !== 1'b0)
			fail_run("timeout: no start bit appeared on tx_line");
		low  = display_low; // displays must be settled once the frame starts
		high = display_high;
		repeat (BIT_CYCLES / 2) @(negedge clk);
		check_bit("tx_line start bit", tx_line, ~LINE_IDLE);
		for (int i = 0; i < FRAME_DATA_BITS; i++)
		begin
			repeat (BIT_CYCLES) @(negedge clk);
			data[i] = tx_line;
		end
		repeat (BIT_CYCLES) @(negedge clk);
		check_bit("tx_line stop bit", tx_line, LINE_IDLE);
	endtask

	task automatic press_button(input logic [7:0] value);
		@(posedge clk);
		sw_data <= value;
		button  <= 1'b1;
		@(posedge clk);
		button  <= 1'b0;
	endtask

	// from mid stop bit past m_tx_done, node back in idle
	task automatic settle();
		repeat (BIT_CYCLES) @(posedge clk);
	endtask

	task automatic watch_idle_line(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			check_bit("tx_line while ignored", tx_line, LINE_IDLE);
		end
	endtask

	task automatic expect_frame(input string name, input logic [7:0] exp);
		logic [7:0] got;
		seg_t       low;
		seg_t       high;
		receive_frame(got, low, high);
		check_byte(name, got, exp);
		check_seg("display_low", low, seg_ref(exp[3:0]));
		check_seg("display_high", high, seg_ref(exp[7:4]));
	endtask

	task automatic after_reset();
		@(negedge clk);
		check_bit("tx_line", tx_line, LINE_IDLE);
		check_seg("display_low", display_low, seg_ref(4'h0));
		check_seg("display_high", display_high, seg_ref(4'h0));
	endtask

	task automatic button_send();
		logic [7:0] v;
		v = rand_byte();
		press_button(v);
		expect_frame("tx byte from switches", v); // no increment on this path
		settle();
	endtask

	task automatic increment_path(input logic [7:0] v);
		send_frame(v);
		expect_frame("tx byte after increment", v + 8'd1);
		settle();
	endtask

	task automatic mode_off_ignored();
		@(posedge clk);
		mode_switch <= 1'b0;
		press_button(rand_byte());
		watch_idle_line(20 * BIT_CYCLES);
		send_frame(rand_byte());
		watch_idle_line(20 * BIT_CYCLES);
		@(posedge clk);
		mode_switch <= 1'b1;
	endtask

	task automatic back_to_back();
		logic [7:0] v1;
		logic [7:0] v2;
		v1 = rand_byte();
		v2 = rand_byte();
		send_frame(v1);
		expect_frame("first tx byte", v1 + 8'd1);
		settle();
		press_button(v2);
		expect_frame("second tx byte", v2);
		settle();
	endtask

	initial
	begin
		lcg_state   = 32'd52474;
		reset       = 1'b1;
		button      = 1'b0;
		mode_switch = 1'b1;
		sw_data     = 8'd0;
		rx_line     = LINE_IDLE;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		after_reset();
		button_send();
		for (int i = 0; i < 4; i++)
			increment_path(rand_byte());
		increment_path(8'hff); // wraps to 0x00
		mode_off_ignored();
		back_to_back();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/increment_node.sv */
// Increment node controller
// Takes a byte from the slave port (or the switches on a button press),
// shows it on two digits, waits, adds one and hands the byte to the
// master port. The switch path sends the byte unchanged.

`timescale 1ns/1ps
`default_nettype none

module increment_node
	import node_pkg::*;
#(
	parameter int WAIT_CYCLES = WAIT_CYCLES_DEFAULT
)
(
	input wire        clk,
	input wire        reset,
	input wire        button,
	input wire        mode_switch,
	input wire  [7:0] sw_data,
	input wire  [7:0] s_data,
	input wire        s_write_en,
	input wire        m_tx_done,
	output wire [7:0] m_data,
	output instr_t    m_instruction,
	output wire seg_t display_low,
	output wire seg_t display_high
);

	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

	node_state_t      state;
	logic [7:0]       value; // byte on the displays and the master port
	logic [CNT_W-1:0] wait_cnt;

	assign m_data = value; // value is stable for the whole data_send state

	seg7_decoder i_digit_low
	(
		.clk      (clk),
		.reset    (reset),
		.nibble   (value[3:0]),
		.segments (display_low)
	);

	seg7_decoder i_digit_high
	(
		.clk      (clk),
		.reset    (reset),
		.nibble   (value[7:4]),
		.segments (display_high)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state         <= idle;
			value         <= 8'd0;
			wait_cnt      <= '0;
			m_instruction <= instr_none;
		end
		else
		begin
			case (state)
				idle:
				begin
					wait_cnt      <= '0;
					m_instruction <= instr_none;
					if (mode_switch && s_write_en) // received byte wins over the button
					begin
						value <= s_data;
						state <= display_and_increment;
					end
					else if (mode_switch && button)
					begin
						value <= sw_data; // sent as is
						state <= data_send;
					end
				end
				display_and_increment:
				begin
					if (wait_cnt == CNT_W'(WAIT_CYCLES))
					begin
						wait_cnt <= '0;
						value    <= value + 8'd1; // wraps at 8 bits
						state    <= data_send;
					end
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				data_send:
				begin
					if (m_tx_done)
					begin
						m_instruction <= instr_none; // drop it with done so no resend
						state         <= idle;
					end
					else
						m_instruction <= instr_send;
				end
				default:
				begin
					m_instruction <= instr_none;
					state         <= idle;
				end
			endcase
		end
	end

	// the transmitter is only asked to send while the node waits for done
	a_instr_only_in_send: assert property (@(posedge clk) disable iff (reset)
		(m_instruction == instr_send) |-> (state == data_send));

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {idle, display_and_increment, data_send});

endmodule

`default_nettype wire

/* design/increment_top.sv */
// Increment node top level
// Joins the node controller with its serial transmitter (master port)
// and serial receiver (slave port).

`timescale 1ns/1ps
`default_nettype none

module increment_top
	import node_pkg::*;
(
	input wire        clk,
	input wire        reset,
	input wire        button,
	input wire        mode_switch,
	input wire  [7:0] sw_data,
	input wire        rx_line,
	output wire       tx_line,
	output wire seg_t display_low,
	output wire seg_t display_high
);

	wire instr_t m_instruction;
	wire [7:0]   m_data;
	wire         m_tx_done;
	wire [7:0]   s_data;
	wire         s_write_en;

	increment_node i_node
	(
		.clk           (clk),
		.reset         (reset),
		.button        (button),
		.mode_switch   (mode_switch),
		.sw_data       (sw_data),
		.s_data        (s_data),
		.s_write_en    (s_write_en),
		.m_tx_done     (m_tx_done),
		.m_data        (m_data),
		.m_instruction (m_instruction),
		.display_low   (display_low),
		.display_high  (display_high)
	);

	serial_tx i_tx
	(
		.clk           (clk),
		.reset         (reset),
		.m_instruction (m_instruction),
		.m_data        (m_data),
		.m_tx_done     (m_tx_done),
		.tx_line       (tx_line)
	);

	serial_rx i_rx
	(
		.clk        (clk),
		.reset      (reset),
		.rx_line    (rx_line),
		.s_data     (s_data),
		.s_write_en (s_write_en)
	);

endmodule

`default_nettype wire

/* design/link_pkg.sv */
// Serial link package
// Frame constants shared by the serial transmitter and receiver.
// A frame is one low start bit, the data bits lsb first and one high stop bit.

`default_nettype none

package link_pkg;

	localparam int BIT_CYCLES      = 8; // clocks per serial bit
	localparam int FRAME_DATA_BITS = 8;

	localparam logic LINE_IDLE = 1'b1; // idle and stop level

endpackage

`default_nettype wire

/* design/node_pkg.sv */
// Node package
// State codes, master-port instruction codes and the seven-segment type
// shared by the increment node and its transmitter.

`default_nettype none

package node_pkg;

	typedef enum logic [1:0]
	{
		idle                  = 2'd0,
		display_and_increment = 2'd1,
		data_send             = 2'd2
	} node_state_t;

	typedef enum logic [1:0]
	{
		instr_none = 2'b00,
		instr_send = 2'b10 // ask the master port to send m_data
	} instr_t;

	typedef logic [6:0] seg_t; // bit 0 is segment a, bit 6 is g, 1 = lit

	localparam int WAIT_CYCLES_DEFAULT = 20; // cycles shown before increment

endpackage

`default_nettype wire

/* design/seg7_decoder.sv */
// Seven-segment decoder
// Registers the hex digit pattern of a 4-bit nibble, one cycle of latency.

`timescale 1ns/1ps
`default_nettype none

module seg7_decoder
	import node_pkg::*;
(
	input wire       clk,
	input wire       reset,
	input wire [3:0] nibble,
	output seg_t     segments
);

	seg_t pattern;

	always_comb
	begin
		case (nibble)
			4'h0: pattern = 7'h3f;
			4'h1: pattern = 7'h06;
			4'h2: pattern = 7'h5b;
			4'h3: pattern = 7'h4f;
			4'h4: pattern = 7'h66;
			4'h5: pattern = 7'h6d;
			4'h6: pattern = 7'h7d;
			4'h7: pattern = 7'h07;
			4'h8: pattern = 7'h7f;
			4'h9: pattern = 7'h6f;
			4'ha: pattern = 7'h77;
			4'hb: pattern = 7'h7c; // lower case b
			4'hc: pattern = 7'h39;
			4'hd: pattern = 7'h5e; // lower case d
			4'he: pattern = 7'h79;
			default: pattern = 7'h71;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			segments <= 7'h3f; // shows 0
		else
			segments <= pattern;
	end

endmodule

`default_nettype wire

/* design/serial_rx.sv */
// Serial receiver (slave port)
// Synchronizes rx_line, finds the start bit, samples each bit at mid-bit
// and strobes s_write_en when the stop bit is high.

`timescale 1ns/1ps
`default_nettype none

module serial_rx
	import link_pkg::*;
(
	input wire         clk,
	input wire         reset,
	input wire         rx_line,
	output wire  [7:0] s_data,
	output logic       s_write_en
);

	localparam int CYC_W = $clog2(BIT_CYCLES + 1);
	localparam int BIT_W = $clog2(FRAME_DATA_BITS + 1);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t                  state;
	logic                       rx_meta;
	logic                       rx_sync;
	logic                       rx_sync_d; // for the falling edge
	logic [CYC_W-1:0]           cyc_cnt;
	logic [BIT_W-1:0]           bit_cnt;
	logic [FRAME_DATA_BITS-1:0] data_sr;
	logic                       mid_bit;

	assign s_data  = data_sr; // only valid with the strobe
	assign mid_bit = (cyc_cnt == CYC_W'(BIT_CYCLES - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta    <= LINE_IDLE;
			rx_sync    <= LINE_IDLE;
			rx_sync_d  <= LINE_IDLE;
			state      <= rx_idle;
			cyc_cnt    <= '0;
			bit_cnt    <= '0;
			s_write_en <= 1'b0;
		end
		else
		begin
			rx_meta    <= rx_line;
			rx_sync    <= rx_meta;
			rx_sync_d  <= rx_sync;
			s_write_en <= 1'b0;
			cyc_cnt    <= cyc_cnt + 1'b1;
			case (state)
				rx_idle:
				begin
					cyc_cnt <= '0;
					bit_cnt <= '0;
					if (rx_sync_d == LINE_IDLE && rx_sync != LINE_IDLE)
						state <= rx_start;
				end
				rx_start:
					if (cyc_cnt == CYC_W'(BIT_CYCLES / 2 - 1)) // middle of start bit
					begin
						cyc_cnt <= '0;
						state   <= (rx_sync != LINE_IDLE) ? rx_data : rx_idle; // glitch check
					end
				rx_data:
					if (mid_bit)
					begin
						cyc_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(FRAME_DATA_BITS - 1))
							state <= rx_stop;
					end
				default:
					if (mid_bit)
					begin
						s_write_en <= (rx_sync == LINE_IDLE); // low stop bit drops the frame
						state      <= rx_idle;
					end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == rx_data && mid_bit)
			data_sr <= {rx_sync, data_sr[FRAME_DATA_BITS-1:1]}; // lsb arrives first
	end

	a_strobe_single: assert property (@(posedge clk) disable iff (reset)
		s_write_en |=> !s_write_en);

endmodule

`default_nettype wire

/* design/serial_tx.sv */
// Serial transmitter (master port)
// Frames m_data as start bit, data lsb first and stop bit when asked by
// instr_send, then pulses m_tx_done for one cycle.

`timescale 1ns/1ps
`default_nettype none

module serial_tx
	import node_pkg::*;
	import link_pkg::*;
(
	input wire       clk,
	input wire       reset,
	input wire instr_t m_instruction,
	input wire [7:0] m_data,
	output logic     m_tx_done,
	output logic     tx_line
);

	localparam int CYC_W = $clog2(BIT_CYCLES + 1);
	localparam int BIT_W = $clog2(FRAME_DATA_BITS + 2);

	logic                       busy;
	logic [CYC_W-1:0]           cyc_cnt;
	logic [BIT_W-1:0]           bit_idx; // 0 is start, FRAME_DATA_BITS+1 is stop
	logic [FRAME_DATA_BITS-1:0] data_sr;
	logic                       start;
	logic                       bit_end;
	logic                       last_bit;

	assign start    = !busy && !m_tx_done && (m_instruction == instr_send);
	assign bit_end  = busy && (cyc_cnt == CYC_W'(BIT_CYCLES - 1));
	assign last_bit = (bit_idx == BIT_W'(FRAME_DATA_BITS + 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy      <= 1'b0;
			cyc_cnt   <= '0;
			bit_idx   <= '0;
			m_tx_done <= 1'b0;
			tx_line   <= LINE_IDLE;
		end
		else
		begin
			m_tx_done <= 1'b0;
			if (start)
			begin
				busy    <= 1'b1;
				cyc_cnt <= '0;
				bit_idx <= '0;
				tx_line <= ~LINE_IDLE; // start bit
			end
			else if (bit_end)
			begin
				cyc_cnt <= '0;
				if (last_bit)
				begin
					busy      <= 1'b0;
					m_tx_done <= 1'b1;
					tx_line   <= LINE_IDLE;
				end
				else
				begin
					bit_idx <= bit_idx + 1'b1;
					tx_line <= data_sr[0]; // stop level once the data is shifted out
				end
			end
			else if (busy)
				cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			data_sr <= m_data;
		else if (bit_end && !last_bit)
			data_sr <= {LINE_IDLE, data_sr[FRAME_DATA_BITS-1:1]};
	end

	a_done_single: assert property (@(posedge clk) disable iff (reset)
		m_tx_done |=> !m_tx_done);

endmodule

`default_nettype wire

/* list.f */
design/node_pkg.sv
design/link_pkg.sv
design/seg7_decoder.sv
design/increment_node.sv
design/serial_tx.sv
design/serial_rx.sv
design/increment_top.sv
bench/tb_increment_top.sv
